//--- game_macros.svh
// Game engine constants
// Board geometry, tile and score widths
// Win tile value and one-hot move direction codes

`ifndef GAME_MACROS_SVH
`define GAME_MACROS_SVH

// Tiles per row and per column
`define BOARD_N 4
// Tile value width, 0 marks an empty cell
`define TILE_W 12
// Score counter width, wraps on overflow
`define SCORE_W 20
// Tile value that raises won
`define WIN_TILE 2048

// One-hot move directions
`define DIR_LEFT  4'b1000
`define DIR_DOWN  4'b0100
`define DIR_UP    4'b0010
`define DIR_RIGHT 4'b0001

`endif

//--- board_pkg.sv
// Board data types
// Tile value, square board array and row or column index

`default_nettype none

`include "game_macros.svh"

package board_pkg;

	// Tile value, 0 is an empty cell
	typedef logic [`TILE_W-1:0] tile_t;

	// Indexed [row][col], row 0 on top and column 0 on the left
	typedef tile_t board_t [`BOARD_N][`BOARD_N];

	// Row or column select
	typedef logic [$clog2(`BOARD_N)-1:0] idx_t;

endpackage

`default_nettype wire

//--- ctrl_pkg.sv
// Control types
// Move direction, score and controller state

`default_nettype none

`include "game_macros.svh"

package ctrl_pkg;

	typedef logic [3:0] dir_t; // One-hot, see DIR_* codes
	typedef logic [`SCORE_W-1:0] score_t; // Wraps on overflow

	typedef enum logic {
		PLAYING = 1'b0, // Moves accepted
		OVER    = 1'b1  // Board full and stuck
	} ctrl_state_e;

endpackage

`default_nettype wire

//--- game_ifs.sv
// Interfaces between the datapath blocks and the controller
// move_result_if carries the slid board and its score gain
// move_status_if carries per-direction move flags and the win flag

`timescale 1ns/1ps
`default_nettype none

interface move_result_if import board_pkg::*, ctrl_pkg::*; ();

	board_t next_board; // Board after the requested move
	score_t gain;       // Sum of merged tile values
	logic   changed;    // next_board differs from current
	logic   dir_ok;     // Direction is a valid one-hot code

	modport src (
		output next_board,
		output gain,
		output changed,
		output dir_ok
	);

	modport dst (
		input next_board,
		input gain,
		input changed,
		input dir_ok
	);

endinterface

interface move_status_if ();

	logic can_left;  // Some tile can slide or merge left
	logic can_down;
	logic can_up;
	logic can_right;
	logic has_win;   // Win tile on the board

	modport src (output can_left, output can_down, output can_up, output can_right,
		output has_win);

	modport dst (input can_left, input can_down, input can_up, input can_right,
		input has_win);

endinterface

`default_nettype wire

//--- tile_slider.sv
// Full slide-and-merge for one move
// Rotates the requested direction onto "down", processes each column,
// rotates back, sums the merge gain and flags a board change

`timescale 1ns/1ps
`default_nettype none

`include "game_macros.svh"

module tile_slider import board_pkg::*, ctrl_pkg::*; (
	input  board_t     board,
	input  dir_t       dir,
	move_result_if.src res
);

	// One column, element 0 at the leading edge
	typedef logic [`BOARD_N-1:0][`TILE_W-1:0] line_t;

	localparam int LAST = `BOARD_N - 1;

	board_t rot;      // Board turned so the move goes down
	board_t slid;     // Rotated board after the slide
	board_t back;     // Slid board in original orientation
	score_t gain_sum;
	logic   diff;

	// Packs nonzero tiles toward the leading edge
	function automatic line_t compact(input line_t l);
		line_t o;
		int    n;
		o = '0;
		n = 0;
		for (int k = 0; k < `BOARD_N; k++) begin
			if (l[k] != '0) begin
				o[n] = l[k];
				n++;
			end
		end
		return o;
	endfunction

	// Merges equal neighbours once each, leading edge first
	function automatic void merge(input line_t l, output line_t o, output score_t g);
		o = l;
		g = '0;
		for (int k = 0; k < LAST; k++) begin
			if (o[k] != '0 && o[k] == o[k+1]) begin
				o[k]   = o[k] << 1; // Doubled tile stays at the lead
				o[k+1] = '0;        // Gap closed by the second compact
				g      = g + score_t'(o[k]);
			end
		end
	endfunction

	always_comb begin
		for (int r = 0; r < `BOARD_N; r++) begin
			for (int c = 0; c < `BOARD_N; c++) begin
				case (dir)
					`DIR_LEFT:  rot[r][c] = board[c][LAST-r]; // Left column to bottom
					`DIR_UP:    rot[r][c] = board[LAST-r][c]; // Vertical flip
					`DIR_RIGHT: rot[r][c] = board[LAST-c][r]; // Right column to bottom
					default:    rot[r][c] = board[r][c];      // Down or invalid
				endcase
			end
		end
	end

	always_comb begin : slide_p
		line_t  ln;
		line_t  mg;
		score_t g;
		gain_sum = '0;
		for (int c = 0; c < `BOARD_N; c++) begin
			for (int k = 0; k < `BOARD_N; k++)
				ln[k] = rot[LAST-k][c]; // Row 3 is the leading edge
			merge(compact(ln), mg, g);
			ln = compact(mg);
			for (int k = 0; k < `BOARD_N; k++)
				slid[LAST-k][c] = ln[k];
			gain_sum = gain_sum + g;
		end
	end

	always_comb begin
		diff = 1'b0;
		for (int r = 0; r < `BOARD_N; r++) begin
			for (int c = 0; c < `BOARD_N; c++) begin
				case (dir)
					`DIR_LEFT:  back[r][c] = slid[LAST-c][r];
					`DIR_UP:    back[r][c] = slid[LAST-r][c];
					`DIR_RIGHT: back[r][c] = slid[c][LAST-r];
					default:    back[r][c] = slid[r][c];
				endcase
				if (back[r][c] != board[r][c])
					diff = 1'b1;
			end
		end
	end

	assign res.next_board = back;
	assign res.gain       = gain_sum;
	assign res.changed    = diff;
	assign res.dir_ok     = (dir == `DIR_LEFT) || (dir == `DIR_DOWN) ||
		(dir == `DIR_UP) || (dir == `DIR_RIGHT);

endmodule

`default_nettype wire

//--- move_checker.sv
// Move availability and win detection for the current board
// A direction can move when some tile has an empty cell or an
// equal tile next to it on that side

`timescale 1ns/1ps
`default_nettype none

`include "game_macros.svh"

module move_checker import board_pkg::*; (
	input  board_t         board,
	move_status_if.src     st
);

	logic left_ok;
	logic down_ok;
	logic up_ok;
	logic right_ok;
	logic win_seen;

	always_comb begin
		left_ok  = 1'b0;
		down_ok  = 1'b0;
		up_ok    = 1'b0;
		right_ok = 1'b0;
		for (int i = 0; i < `BOARD_N; i++) begin
			for (int j = 0; j < `BOARD_N-1; j++) begin
				// Horizontal pair, (i,j) left of (i,j+1)
				if (board[i][j+1] != '0 && (board[i][j] == '0 || board[i][j] == board[i][j+1]))
					left_ok = 1'b1;
				if (board[i][j] != '0 && (board[i][j+1] == '0 || board[i][j+1] == board[i][j]))
					right_ok = 1'b1;
				// Vertical pair, (j,i) above (j+1,i)
				if (board[j+1][i] != '0 && (board[j][i] == '0 || board[j][i] == board[j+1][i]))
					up_ok = 1'b1;
				if (board[j][i] != '0 && (board[j+1][i] == '0 || board[j+1][i] == board[j][i]))
					down_ok = 1'b1;
			end
		end
	end

	always_comb begin
		win_seen = 1'b0;
		for (int r = 0; r < `BOARD_N; r++)
			for (int c = 0; c < `BOARD_N; c++)
				if (board[r][c] == tile_t'(`WIN_TILE))
					win_seen = 1'b1;
	end

	assign st.can_left  = left_ok;
	assign st.can_down  = down_ok;
	assign st.can_up    = up_ok;
	assign st.can_right = right_ok;
	assign st.has_win   = win_seen;

endmodule

`default_nettype wire

//--- board_controller.sv
// Board, score and game-state registers
// Applies clear, move and place commands in that priority,
// issues the moved pulse and tracks the game-over state

`timescale 1ns/1ps
`default_nettype none

`include "game_macros.svh"

module board_controller import board_pkg::*, ctrl_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       move,
	input  logic       place,
	input  logic       clear,
	input  idx_t       place_row,
	input  idx_t       place_col,
	input  tile_t      place_val,
	move_result_if.dst res,
	move_status_if.dst st,
	output board_t     board,
	output score_t     score,
	output logic       moved,
	output logic       over
);

	ctrl_state_e state;
	logic        apply_move; // Move accepted this cycle
	logic        place_ok;   // Target empty and value nonzero
	logic        full;       // No empty cell left
	logic        stuck;      // Full board with no move in any direction

	assign apply_move = move && res.dir_ok && res.changed && (state == PLAYING);
	assign place_ok   = place && (place_val != '0) && (board[place_row][place_col] == '0);

	always_comb begin
		full = 1'b1;
		for (int r = 0; r < `BOARD_N; r++)
			for (int c = 0; c < `BOARD_N; c++)
				if (board[r][c] == '0)
					full = 1'b0;
	end

	// An empty board also has no move, so fullness gates game over
	assign stuck = full && !(st.can_left || st.can_down || st.can_up || st.can_right);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			board <= '{default: '0};
			score <= '0;
			moved <= 1'b0;
			state <= PLAYING;
		end else begin
			moved <= 1'b0; // Pulse by default low
			if (clear) begin
				board <= '{default: '0};
				score <= '0;
				state <= PLAYING;
			end else begin
				if (move) begin
					if (apply_move) begin
						board <= res.next_board;
						score <= score + res.gain; // Wraps at SCORE_W
						moved <= 1'b1;
					end
				end else if (place_ok) begin
					board[place_row][place_col] <= place_val;
				end
				// Tracks the board one edge late
				state <= stuck ? OVER : PLAYING;
			end
		end
	end

	assign over = (state == OVER);

endmodule

`default_nettype wire

//--- game2048_top.sv
// Sliding-tile game engine top level
// Controller, slider and move checker around one board register,
// board flattened onto a single output vector

`timescale 1ns/1ps
`default_nettype none

`include "game_macros.svh"

module game2048_top import board_pkg::*, ctrl_pkg::*; (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  move,
	input  dir_t                                  dir,
	input  logic                                  place,
	input  idx_t                                  place_row,
	input  idx_t                                  place_col,
	input  tile_t                                 place_val,
	input  logic                                  clear,
	output logic [`BOARD_N*`BOARD_N*`TILE_W-1:0] board_flat,
	output score_t                                score,
	output logic                                  moved,
	output logic                                  won,
	output logic                                  over
);

	board_t board; // Current board register

	move_result_if res_if ();
	move_status_if st_if ();

	board_controller ctrl_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.move      (move),
		.place     (place),
		.clear     (clear),
		.place_row (place_row),
		.place_col (place_col),
		.place_val (place_val),
		.res       (res_if.dst),
		.st        (st_if.dst),
		.board     (board),
		.score     (score),
		.moved     (moved),
		.over      (over)
	);

	tile_slider slider_i (
		.board (board),
		.dir   (dir),
		.res   (res_if.src)
	);

	move_checker checker_i (
		.board (board),
		.st    (st_if.src)
	);

	assign won = st_if.has_win; // Straight from the current board

	always_comb begin
		for (int r = 0; r < `BOARD_N; r++)
			for (int c = 0; c < `BOARD_N; c++)
				board_flat[(r*`BOARD_N+c)*`TILE_W +: `TILE_W] = board[r][c]; // Cell (0,0) lowest
	end

endmodule

`default_nettype wire

//--- game_properties.sv
// Concurrent checks on the board controller
// Moved pulse against board change, game over against move flags,
// score that only grows outside clear

`timescale 1ns/1ps
`default_nettype none

`include "game_macros.svh"

module game_properties import board_pkg::*, ctrl_pkg::*; (
	input logic   clk,
	input logic   rst_n,
	input logic   clear,
	input logic   moved,
	input logic   over,
	input score_t score,
	input board_t board,
	input logic   can_left,
	input logic   can_down,
	input logic   can_up,
	input logic   can_right
);

	logic [`BOARD_N*`BOARD_N*`TILE_W-1:0] flat; // Board packed for $past

	always_comb begin
		for (int r = 0; r < `BOARD_N; r++)
			for (int c = 0; c < `BOARD_N; c++)
				flat[(r*`BOARD_N+c)*`TILE_W +: `TILE_W] = board[r][c];
	end

	moved_changes_board: assert property (@(posedge clk) disable iff (!rst_n)
		moved |-> (flat != $past(flat)))
		else $error("moved pulse without a board change");

	over_means_stuck: assert property (@(posedge clk) disable iff (!rst_n)
		over |-> !(can_left || can_down || can_up || can_right))
		else $error("over raised while a direction can still move");

	score_grows: assert property (@(posedge clk) disable iff (!rst_n)
		!$past(clear) |-> (score >= $past(score)))
		else $error("score dropped without a clear");

endmodule

bind board_controller game_properties props_i (
	.clk       (clk),
	.rst_n     (rst_n),
	.clear     (clear),
	.moved     (moved),
	.over      (over),
	.score     (score),
	.board     (board),
	.can_left  (st.can_left),
	.can_down  (st.can_down),
	.can_up    (st.can_up),
	.can_right (st.can_right)
);

`default_nettype wire

//--- tb_game2048.sv
// Testbench for the sliding-tile game engine
// LCG stimulus, reference model with direct per-direction slides,
// immediate checks after every command, watchdog and final verdict

`timescale 1ns/1ps
`default_nettype none

`include "game_macros.svh"

module tb_game2048 import board_pkg::*, ctrl_pkg::*; ();

	localparam int SEED        = 29130;
	localparam int RESET_CYC   = 5;
	localparam int DIRECT_CYC  = 40;   // Upper bound of the directed part
	localparam int RAND_CYC    = 3000;
	localparam int WATCHDOG_NS = (RESET_CYC + DIRECT_CYC + RAND_CYC + 50) * 40;
	localparam int N           = `BOARD_N;
	localparam int LAST        = N - 1;
	localparam int FLAT_W      = N * N * `TILE_W;

	typedef tile_t line_t [`BOARD_N]; // Index 0 at the leading edge

	logic              clk = 1'b0;
	logic              rst_n;
	logic              move;
	dir_t              dir;
	logic              place;
	idx_t              place_row;
	idx_t              place_col;
	tile_t             place_val;
	logic              clear;
	logic [FLAT_W-1:0] board_flat;
	score_t            score;
	logic              moved;
	logic              won;
	logic              over;

	logic [31:0] lcg_state = SEED;
	board_t      m_board;        // Model board
	score_t      m_score;
	logic        m_moved;
	logic        m_over;         // Model state register
	int          err_board = 0;
	int          err_score = 0;
	int          err_moved = 0;
	int          err_won   = 0;
	int          err_over  = 0;
	int          err_seq   = 0;  // Directed won and over checks

	game2048_top dut_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.move       (move),
		.dir        (dir),
		.place      (place),
		.place_row  (place_row),
		.place_col  (place_col),
		.place_val  (place_val),
		.clear      (clear),
		.board_flat (board_flat),
		.score      (score),
		.moved      (moved),
		.won        (won),
		.over       (over)
	);

	always #20 clk = ~clk; // 40 ns period

	function automatic int rand_below(input int n);
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return int'(lcg_state[30:16]) % n; // Upper bits spread better
	endfunction

	function automatic logic [FLAT_W-1:0] flatten(input board_t b);
		logic [FLAT_W-1:0] f;
		for (int r = 0; r < N; r++)
			for (int c = 0; c < N; c++)
				f[(r*N+c)*`TILE_W +: `TILE_W] = b[r][c]; // Cell (0,0) lowest
		return f;
	endfunction

	// Gathers tiles, then pairs them up front to back, one merge per tile
	function automatic void slide_line(input line_t li, output line_t lo, inout score_t gain);
		tile_t vals [`BOARD_N];
		int    n;
		int    k;
		int    o;
		vals = '{default: '0};
		lo   = '{default: '0};
		n = 0;
		for (int i = 0; i < N; i++) begin
			if (li[i] != '0) begin
				vals[n] = li[i];
				n++;
			end
		end
		k = 0;
		o = 0;
		while (k < n) begin
			if (k + 1 < n && vals[k] == vals[k+1]) begin
				lo[o] = vals[k] << 1;
				gain  = gain + score_t'(lo[o]);
				k += 2; // Both tiles consumed
			end else begin
				lo[o] = vals[k];
				k++;
			end
			o++;
		end
	endfunction

	function automatic void slide_board(input dir_t d, input board_t b, output board_t nb,
		output score_t gain);
		line_t li;
		line_t lo;
		gain = '0;
		nb   = b;
		for (int i = 0; i < N; i++) begin
			for (int k = 0; k < N; k++) begin
				case (d)
					`DIR_LEFT:  li[k] = b[i][k];
					`DIR_RIGHT: li[k] = b[i][LAST-k];
					`DIR_UP:    li[k] = b[k][i];
					default:    li[k] = b[LAST-k][i]; // Down
				endcase
			end
			slide_line(li, lo, gain);
			for (int k = 0; k < N; k++) begin
				case (d)
					`DIR_LEFT:  nb[i][k]      = lo[k];
					`DIR_RIGHT: nb[i][LAST-k] = lo[k];
					`DIR_UP:    nb[k][i]      = lo[k];
					default:    nb[LAST-k][i] = lo[k];
				endcase
			end
		end
	endfunction

	// Full board on which no direction changes anything
	function automatic logic is_stuck(input board_t b);
		board_t nb;
		score_t g;
		logic   s;
		s = 1'b1;
		for (int r = 0; r < N; r++)
			for (int c = 0; c < N; c++)
				if (b[r][c] == '0)
					s = 1'b0;
		for (int i = 0; i < 4; i++) begin
			slide_board(dir_t'(4'b1 << i), b, nb, g); // All four one-hot codes
			if (flatten(nb) != flatten(b))
				s = 1'b0;
		end
		return s;
	endfunction

	function automatic logic has_win(input board_t b);
		logic w;
		w = 1'b0;
		for (int r = 0; r < N; r++)
			for (int c = 0; c < N; c++)
				if (b[r][c] == tile_t'(`WIN_TILE))
					w = 1'b1;
		return w;
	endfunction

	// Model of one clock edge with the command the DUT samples there
	task automatic model_edge();
		board_t nb;
		score_t g;
		logic   stuck_now;
		stuck_now = is_stuck(m_board); // State follows the pre-edge board
		m_moved   = 1'b0;
		if (clear) begin
			m_board = '{default: '0};
			m_score = '0;
			m_over  = 1'b0;
		end else begin
			if (move) begin
				if ($onehot(dir) && !m_over) begin
					slide_board(dir, m_board, nb, g);
					if (flatten(nb) != flatten(m_board)) begin
						m_board = nb;
						m_score = m_score + g;
						m_moved = 1'b1;
					end
				end
			end else if (place && place_val != '0 && m_board[place_row][place_col] == '0) begin
				m_board[place_row][place_col] = place_val;
			end
			m_over = stuck_now;
		end
	endtask

	task automatic check_outputs();
		assert (board_flat == flatten(m_board)) else begin
			err_board++;
			$display("Mismatch at %0t: board_flat expected %h got %h",
				$time, flatten(m_board), board_flat);
		end
		assert (score == m_score) else begin
			err_score++;
			$display("Mismatch at %0t: score expected %0d got %0d", $time, m_score, score);
		end
		assert (moved == m_moved) else begin
			err_moved++;
			$display("Mismatch at %0t: moved expected %b got %b", $time, m_moved, moved);
		end
		assert (won == has_win(m_board)) else begin
			err_won++;
			$display("Mismatch at %0t: won expected %b got %b", $time, has_win(m_board), won);
		end
		assert (over == m_over) else begin
			err_over++;
			$display("Mismatch at %0t: over expected %b got %b", $time, m_over, over);
		end
	endtask

	task automatic send_command(input logic mv, input dir_t d, input logic pl, input idx_t r,
		input idx_t c, input tile_t v, input logic cl);
		@(posedge clk);
		model_edge(); // Command driven last cycle lands now
		move      <= mv;
		dir       <= d;
		place     <= pl;
		place_row <= r;
		place_col <= c;
		place_val <= v;
		clear     <= cl;
		@(negedge clk);
		check_outputs(); // Outputs settled by mid-cycle
	endtask

	task automatic idle_cycle();
		send_command(1'b0, '0, 1'b0, '0, '0, '0, 1'b0);
	endtask

	task automatic place_tile(input int r, input int c, input int v);
		send_command(1'b0, '0, 1'b1, idx_t'(r), idx_t'(c), tile_t'(v), 1'b0);
	endtask

	task automatic send_move(input dir_t d);
		send_command(1'b1, d, 1'b0, '0, '0, '0, 1'b0);
	endtask

	task automatic clear_board();
		send_command(1'b0, '0, 1'b0, '0, '0, '0, 1'b1);
	endtask

	initial begin : watchdog_p
		#(WATCHDOG_NS);
		$display("Watchdog expired at %0t before the test finished", $time);
		$display("TEST FAIL");
		$finish;
	end

	initial begin : main_p
		int    sel;
		int    total;
		idx_t  rr;
		idx_t  cc;
		tile_t vv;
		dir_t  dd;
		rst_n     = 1'b0;
		move      = 1'b0;
		dir       = '0;
		place     = 1'b0;
		place_row = '0;
		place_col = '0;
		place_val = '0;
		clear     = 1'b0;
		m_board   = '{default: '0};
		m_score   = '0;
		m_moved   = 1'b0;
		m_over    = 1'b0;
		repeat (RESET_CYC) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_outputs(); // Reset values

		// Two 1024 tiles merge into the win tile
		place_tile(0, 0, 1024);
		place_tile(0, 1, 1024);
		send_move(`DIR_LEFT);
		idle_cycle();
		assert (won == 1'b1) else begin
			err_seq++;
			$display("Mismatch at %0t: won expected 1 got %b", $time, won);
		end

		// 2 2 4 slides to 4 4 and the new 4 stays put
		clear_board();
		place_tile(1, 0, 2);
		place_tile(1, 1, 2);
		place_tile(1, 2, 4);
		send_move(`DIR_LEFT);

		// Checkerboard of 2 and 4 leaves no move
		clear_board();
		for (int r = 0; r < N; r++)
			for (int c = 0; c < N; c++)
				place_tile(r, c, ((r + c) % 2) ? 2 : 4);
		idle_cycle();
		idle_cycle();
		assert (over == 1'b1) else begin
			err_seq++;
			$display("Mismatch at %0t: over expected 1 got %b", $time, over);
		end
		send_move(`DIR_UP);  // Ignored while over
		place_tile(0, 0, 8); // Occupied cell
		clear_board();
		idle_cycle();

		for (int i = 0; i < RAND_CYC; i++) begin
			sel = rand_below(100);
			rr  = idx_t'(rand_below(N));
			cc  = idx_t'(rand_below(N));
			vv  = (rand_below(10) == 0) ? tile_t'(4) : tile_t'(2);
			dd  = dir_t'(4'b1 << rand_below(4));
			if (sel < 2)
				clear_board();
			else if (sel < 42)
				send_move(dd);
			else if (sel < 47)
				send_command(1'b1, dir_t'(rand_below(16)), 1'b0, rr, cc, vv, 1'b0); // Any code
			else if (sel < 52)
				send_command(1'b1, dd, 1'b1, rr, cc, vv, 1'b0); // Move beats place
			else if (sel < 55)
				send_command(1'b0, '0, 1'b1, rr, cc, '0, 1'b0); // Zero value
			else if (sel < 90)
				send_command(1'b0, '0, 1'b1, rr, cc, vv, 1'b0);
			else
				idle_cycle();
		end
		idle_cycle(); // Result of the last command

		total = err_board + err_score + err_moved + err_won + err_over + err_seq;
		$display("Errors: board %0d, score %0d, moved %0d, won %0d, over %0d, directed %0d",
			err_board, err_score, err_moved, err_won, err_over, err_seq);
		if (total == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
board_pkg.sv
ctrl_pkg.sv
game_ifs.sv
tile_slider.sv
move_checker.sv
board_controller.sv
game2048_top.sv
game_properties.sv
tb_game2048.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_game2048
FILELIST = tb.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
PASS_MSG = TEST PASS

SRCS = $(filter-out +incdir+%,$(shell cat $(FILELIST))) game_macros.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
